/* rp_pkg.sv */
// Shared widths and types assume 16-bit raw ADC lanes trimmed to 14-bit signed samples on adc_clk

package rp_pkg;

  //////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;        // Raw lane from the deserializer
  localparam int SAMPLE_W  = 14;        // Signal sample
  localparam int SUM_W     = 15;        // Mixer sum before saturation

  // Reset hold after PLL lock
  localparam int RST_HOLD_CYCLES = 64;
  localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES);

  //////////////////////////////////////////////////
  // Daisy chain word and mode control
  //////////////////////////////////////////////////

  localparam int DAISY_W      = 16;
  localparam int DAISY_MODE_W = 3;

  localparam int DAISY_SYNC_BIT   = 0;  // Sync mode, trigger goes on the daisy link
  localparam int TRIG_PIN_EN_BIT  = 1;  // Expansion pin output enable
  localparam int TRIG_SRC_GEN_BIT = 2;  // Generator trigger instead of scope

  // Types
  typedef logic        [ADC_RAW_W-1:0] raw_t;
  typedef logic signed [SAMPLE_W-1:0]  sample_t;
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // Offset binary, negative slope
  typedef logic        [DAISY_W-1:0]   daisy_word_t;

  localparam daisy_word_t DAISY_IDLE_WORD = 16'h1234;  // Test pattern outside sync

  // Saturation limits
  localparam sample_t SAMPLE_MAX = sample_t'(8191);
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);

  // Digital loop select
  // Bit 0 feeds the ADC stream from the DAC, bit 1 feeds the DAC from the ADC
  typedef enum logic [1:0] {
    LOOP_NONE         = 2'b00,
    LOOP_ADC_FROM_DAC = 2'b01,
    LOOP_DAC_FROM_ADC = 2'b10,
    LOOP_BOTH         = 2'b11
  } loop_mode_e;

  // Reset sequencer states
  typedef enum logic [1:0] {
    SEQ_UNLOCKED = 2'd0,  // Waiting for lock edge
    SEQ_HOLD     = 2'd1,  // Core held in reset
    SEQ_RUN      = 2'd2   // Normal operation
  } seq_state_e;

endpackage

/* rp_reset_seq.sv */
// Core reset follows reset_i with one cycle lag and a lock drop releases it without a new hold
`timescale 1ns/1ps

module rp_reset_seq import rp_pkg::*; (
  input  logic adc_clk,
  input  logic reset_i,       // Board level reset
  input  logic pll_locked_i,  // PLL lock status
  output logic core_reset_o   // Reset for the analog front end
);

  seq_state_e           state;
  seq_state_e           state_nxt;
  logic                 lock_q;    // Previous lock sample
  logic [RST_CNT_W-1:0] hold_cnt;  // Cycles spent in hold
  logic                 lock_edge;

  assign lock_edge = pll_locked_i & ~lock_q;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    if (!pll_locked_i) begin
      state_nxt = SEQ_UNLOCKED;  // Lost lock, no reset pulse
    end else begin
      case (state)
        SEQ_UNLOCKED: if (lock_edge) state_nxt = SEQ_HOLD;
        SEQ_HOLD:     if (hold_cnt == RST_CNT_W'(RST_HOLD_CYCLES - 1)) state_nxt = SEQ_RUN;
        default:      state_nxt = state;
      endcase
    end
  end

  // State, lock history and hold counter
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      state        <= SEQ_UNLOCKED;
      lock_q       <= 1'b0;
      hold_cnt     <= '0;
      core_reset_o <= 1'b1;
    end else begin
      state        <= state_nxt;
      lock_q       <= pll_locked_i;
      core_reset_o <= (state_nxt == SEQ_HOLD);
      if (state == SEQ_HOLD && state_nxt == SEQ_HOLD)
        hold_cnt <= hold_cnt + 1'b1;  // Counting hold cycles
      else
        hold_cnt <= '0;
    end
  end

  // Hold never outlasts its count
  a_hold_len: assert property (@(posedge adc_clk) disable iff (reset_i)
    $rose(core_reset_o) |-> ##[1:RST_HOLD_CYCLES] !core_reset_o);

endmodule

/* rp_adc_capture.sv */
// Loop samples must come registered from the mixer and raw lanes are trimmed without rounding
`timescale 1ns/1ps

module rp_adc_capture import rp_pkg::*; (
  input  logic       adc_clk,
  input  logic       core_reset_i,
  input  raw_t       adc_raw_a_i,     // Raw lane A
  input  raw_t       adc_raw_b_i,     // Raw lane B
  input  logic       adc_raw_valid_i,
  input  loop_mode_e loop_mode_i,
  input  sample_t    loop_a_i,        // Mixer sample for the ADC loop
  input  sample_t    loop_b_i,
  output sample_t    adc_a_o,
  output sample_t    adc_b_o,
  output logic       adc_valid_o,
  output dac_code_t  raw_top_a_o,     // Trimmed bits for the DAC loop
  output dac_code_t  raw_top_b_o
);

  dac_code_t trim_a;
  dac_code_t trim_b;
  logic      adc_loop;

  // Keep upper bits only
  assign trim_a   = adc_raw_a_i[ADC_RAW_W-1 -: SAMPLE_W];
  assign trim_b   = adc_raw_b_i[ADC_RAW_W-1 -: SAMPLE_W];
  assign adc_loop = loop_mode_i[0];

  //////////////////////////////////////////////////
  // Capture register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (core_reset_i) begin
      adc_a_o     <= '0;
      adc_b_o     <= '0;
      adc_valid_o <= 1'b0;
    end else begin
      adc_a_o     <= adc_loop ? loop_a_i : sample_t'(trim_a);
      adc_b_o     <= adc_loop ? loop_b_i : sample_t'(trim_b);
      adc_valid_o <= adc_loop | adc_raw_valid_i;  // Loop data is always valid
    end
  end

  // Trimmed bits forwarded to the DAC stage
  always_ff @(posedge adc_clk) begin
    raw_top_a_o <= trim_a;
    raw_top_b_o <= trim_b;
  end

  a_loop_valid: assert property (@(posedge adc_clk) disable iff (core_reset_i)
    loop_mode_i[0] |=> adc_valid_o);

endmodule

/* rp_dac_mixer.sv */
// Sums generator and controller samples per channel and clamps to 14 bits with one cycle latency
`timescale 1ns/1ps

module rp_dac_mixer import rp_pkg::*; (
  input  logic    adc_clk,
  input  logic    core_reset_i,
  input  sample_t gen_a_i,   // Generator channel A
  input  sample_t gen_b_i,   // Generator channel B
  input  sample_t ctrl_a_i,  // Controller channel A
  input  sample_t ctrl_b_i,  // Controller channel B
  output sample_t mix_a_o,
  output sample_t mix_b_o
);

  //////////////////////////////////////////////////
  // Saturating add
  //////////////////////////////////////////////////

  // Wide sum, then clamp when the top two bits disagree
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic signed [SUM_W-1:0] sum;
    sum = SUM_W'(a) + SUM_W'(b);  // Sign extended operands
    if (sum[SUM_W-1] ^ sum[SUM_W-2])
      sat_add = sum[SUM_W-1] ? SAMPLE_MIN : SAMPLE_MAX;  // Sign picks the rail
    else
      sat_add = sum[SAMPLE_W-1:0];
  endfunction

  sample_t sat_a;
  sample_t sat_b;

  assign sat_a = sat_add(gen_a_i, ctrl_a_i);
  assign sat_b = sat_add(gen_b_i, ctrl_b_i);

  // Output register
  always_ff @(posedge adc_clk) begin
    if (core_reset_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;  // Feeds DAC stage and ADC loop
      mix_b_o <= sat_b;
    end
  end

endmodule

/* rp_dac_output.sv */
// DAC code is offset binary with negative slope and the ADC loop bypasses the conversion
`timescale 1ns/1ps

module rp_dac_output import rp_pkg::*; (
  input  logic       adc_clk,
  input  logic       core_reset_i,
  input  loop_mode_e loop_mode_i,
  input  sample_t    mix_a_i,      // Saturated mixer samples
  input  sample_t    mix_b_i,
  input  dac_code_t  raw_top_a_i,  // Trimmed ADC bits
  input  dac_code_t  raw_top_b_i,
  output dac_code_t  dac_a_o,
  output dac_code_t  dac_b_o
);

  // Sign kept, magnitude bits inverted
  function automatic dac_code_t to_dac_code(input sample_t s);
    to_dac_code = {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

  logic dac_loop;

  assign dac_loop = loop_mode_i[1];

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (core_reset_i) begin
      dac_a_o <= to_dac_code('0);  // Mid scale
      dac_b_o <= to_dac_code('0);
    end else begin
      dac_a_o <= dac_loop ? raw_top_a_i : to_dac_code(mix_a_i);
      dac_b_o <= dac_loop ? raw_top_b_i : to_dac_code(mix_b_i);
    end
  end

endmodule

/* rp_trig_route.sv */
// Mode bits act as levels sampled each cycle and the daisy link words are parallel only
`timescale 1ns/1ps

module rp_trig_route import rp_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    core_reset_i,
  input  logic                    ext_trig_pin_i,  // External trigger pin
  input  logic [DAISY_MODE_W-1:0] daisy_mode_i,
  input  daisy_word_t             daisy_rx_dat_i,  // Word from previous board
  input  logic                    daisy_rx_rdy_i,
  input  logic                    scope_trig_i,
  input  logic                    gen_trig_i,
  output logic                    trig_ext_o,
  output logic                    trig_pin_o,
  output logic                    trig_pin_oe_o,
  output daisy_word_t             daisy_tx_dat_o,  // Word to next board
  output logic                    daisy_tx_dv_o
);

  logic sync_mode;
  logic daisy_trig;
  logic trig_sel;

  assign sync_mode  = daisy_mode_i[DAISY_SYNC_BIT];
  assign daisy_trig = |daisy_rx_dat_i;  // Any set bit counts
  assign trig_sel   = daisy_mode_i[TRIG_SRC_GEN_BIT] ? gen_trig_i : scope_trig_i;

  //////////////////////////////////////////////////
  // Routing registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (core_reset_i) begin
      trig_ext_o     <= 1'b0;
      trig_pin_o     <= 1'b0;
      trig_pin_oe_o  <= 1'b0;
      daisy_tx_dat_o <= '0;
      daisy_tx_dv_o  <= 1'b0;
    end else begin
      // Daisy trigger masks the pin in sync mode
      trig_ext_o    <= ext_trig_pin_i & ~(sync_mode & daisy_trig);
      trig_pin_o    <= trig_sel;
      trig_pin_oe_o <= daisy_mode_i[TRIG_PIN_EN_BIT];
      if (sync_mode) begin
        daisy_tx_dat_o <= {DAISY_W{trig_sel}};  // Trigger replicated
        daisy_tx_dv_o  <= 1'b0;
      end else begin
        daisy_tx_dat_o <= DAISY_IDLE_WORD;
        daisy_tx_dv_o  <= daisy_rx_rdy_i;      // Echo receiver ready
      end
    end
  end

  a_sync_no_dv: assert property (@(posedge adc_clk) disable iff (core_reset_i)
    daisy_mode_i[DAISY_SYNC_BIT] |=> !daisy_tx_dv_o);

endmodule

/* rp_frontend_top.sv */
// Single clock domain on adc_clk and upstream cores are replaced by their sample and trigger ports
`timescale 1ns/1ps

module rp_frontend_top import rp_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    reset_i,
  // PLL and reset
  input  logic                    pll_locked_i,
  output logic                    core_reset_o,
  // ADC raw lanes
  input  raw_t                    adc_raw_a_i,
  input  raw_t                    adc_raw_b_i,
  input  logic                    adc_raw_valid_i,
  input  loop_mode_e              loop_mode_i,
  // Generator and controller samples
  input  sample_t                 gen_a_i,
  input  sample_t                 gen_b_i,
  input  sample_t                 ctrl_a_i,
  input  sample_t                 ctrl_b_i,
  // ADC stream
  output sample_t                 adc_a_o,
  output sample_t                 adc_b_o,
  output logic                    adc_valid_o,
  // DAC codes
  output dac_code_t               dac_a_o,
  output dac_code_t               dac_b_o,
  // Triggers and daisy words
  input  logic                    ext_trig_pin_i,
  input  logic [DAISY_MODE_W-1:0] daisy_mode_i,
  input  daisy_word_t             daisy_rx_dat_i,
  input  logic                    daisy_rx_rdy_i,
  input  logic                    scope_trig_i,
  input  logic                    gen_trig_i,
  output logic                    trig_ext_o,
  output logic                    trig_pin_o,
  output logic                    trig_pin_oe_o,
  output daisy_word_t             daisy_tx_dat_o,
  output logic                    daisy_tx_dv_o
);

  sample_t   mix_a, mix_b;          // Registered mixer samples
  dac_code_t raw_top_a, raw_top_b;  // Trimmed raw bits

  //////////////////////////////////////////////////
  // Reset and data path
  //////////////////////////////////////////////////

  rp_reset_seq i_reset_seq (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .pll_locked_i (pll_locked_i),
    .core_reset_o (core_reset_o)
  );

  rp_adc_capture i_adc_capture (
    .adc_clk         (adc_clk),
    .core_reset_i    (core_reset_o),
    .adc_raw_a_i     (adc_raw_a_i),
    .adc_raw_b_i     (adc_raw_b_i),
    .adc_raw_valid_i (adc_raw_valid_i),
    .loop_mode_i     (loop_mode_i),
    .loop_a_i        (mix_a),  // ADC loop source
    .loop_b_i        (mix_b),
    .adc_a_o         (adc_a_o),
    .adc_b_o         (adc_b_o),
    .adc_valid_o     (adc_valid_o),
    .raw_top_a_o     (raw_top_a),
    .raw_top_b_o     (raw_top_b)
  );

  rp_dac_mixer i_dac_mixer (
    .adc_clk      (adc_clk),
    .core_reset_i (core_reset_o),
    .gen_a_i      (gen_a_i),
    .gen_b_i      (gen_b_i),
    .ctrl_a_i     (ctrl_a_i),
    .ctrl_b_i     (ctrl_b_i),
    .mix_a_o      (mix_a),
    .mix_b_o      (mix_b)
  );

  rp_dac_output i_dac_output (
    .adc_clk      (adc_clk),
    .core_reset_i (core_reset_o),
    .loop_mode_i  (loop_mode_i),
    .mix_a_i      (mix_a),
    .mix_b_i      (mix_b),
    .raw_top_a_i  (raw_top_a),  // DAC loop source
    .raw_top_b_i  (raw_top_b),
    .dac_a_o      (dac_a_o),
    .dac_b_o      (dac_b_o)
  );

  // Trigger routing
  rp_trig_route i_trig_route (
    .adc_clk        (adc_clk),
    .core_reset_i   (core_reset_o),
    .ext_trig_pin_i (ext_trig_pin_i),
    .daisy_mode_i   (daisy_mode_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .scope_trig_i   (scope_trig_i),
    .gen_trig_i     (gen_trig_i),
    .trig_ext_o     (trig_ext_o),
    .trig_pin_o     (trig_pin_o),
    .trig_pin_oe_o  (trig_pin_oe_o),
    .daisy_tx_dat_o (daisy_tx_dat_o),
    .daisy_tx_dv_o  (daisy_tx_dv_o)
  );

endmodule

/* tb_rp_frontend.sv */
// Directed tests assume one sample per cycle and lock held high after the reset test
`timescale 1ns/1ps

module tb_rp_frontend import rp_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;  // Several times the whole run

  logic                    adc_clk = 1'b0;
  logic                    reset_i;
  logic                    pll_locked_i;
  logic                    core_reset_o;
  raw_t                    adc_raw_a_i, adc_raw_b_i;
  logic                    adc_raw_valid_i;
  loop_mode_e              loop_mode_i;
  sample_t                 gen_a_i, gen_b_i, ctrl_a_i, ctrl_b_i;
  sample_t                 adc_a_o, adc_b_o;
  logic                    adc_valid_o;
  dac_code_t               dac_a_o, dac_b_o;
  logic                    ext_trig_pin_i;
  logic [DAISY_MODE_W-1:0] daisy_mode_i;
  daisy_word_t             daisy_rx_dat_i;
  logic                    daisy_rx_rdy_i, scope_trig_i, gen_trig_i;
  logic                    trig_ext_o, trig_pin_o, trig_pin_oe_o;
  daisy_word_t             daisy_tx_dat_o;
  logic                    daisy_tx_dv_o;
  int                      cycle_cnt = 0;
  int                      error_count = 0;

  rp_frontend_top i_rp_frontend_top (.*);

  always #4 adc_clk = ~adc_clk;  // 8 ns period

  // Watchdog
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  //////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // Step just past the edge where outputs are stable
  task automatic tick();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic check_sample(string name, sample_t exp, sample_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
      error_count++;
      stop_with_failure();
    end
  endtask

  task automatic check_dac(string name, dac_code_t exp, dac_code_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      error_count++;
      stop_with_failure();
    end
  endtask

  task automatic check_word(string name, daisy_word_t exp, daisy_word_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      error_count++;
      stop_with_failure();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      error_count++;
      stop_with_failure();
    end
  endtask

  // Reference sum on plain integers clamped to the 14-bit rails
  function automatic sample_t clamp_sum(sample_t a, sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > int'(SAMPLE_MAX)) s = int'(SAMPLE_MAX);
    else if (s < int'(SAMPLE_MIN)) s = int'(SAMPLE_MIN);
    return sample_t'(s);
  endfunction

  // Negative slope around mid scale so 0 maps to 8191
  function automatic dac_code_t expected_code(sample_t s);
    return dac_code_t'(int'(SAMPLE_MAX) - int'(s));
  endfunction

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_hold();
    check_bit("reset_hold idle", 1'b0, core_reset_o);  // No lock yet
    for (int r = 0; r < 2; r++) begin
      pll_locked_i = 1'b1;
      tick();
      check_bit("reset_hold start", 1'b1, core_reset_o);
      loop_mode_i     = LOOP_BOTH;  // Both loops would reach the outputs
      adc_raw_valid_i = 1'b1;       // Must stay masked by the hold
      adc_raw_a_i     = 16'hA5A4;   // Trims to a code far from mid scale
      for (int i = 1; i < RST_HOLD_CYCLES; i++) begin
        tick();
        check_bit("reset_hold core_reset", 1'b1, core_reset_o);
        check_dac("reset_hold dac_a", 14'h1FFF, dac_a_o);
        check_bit("reset_hold adc_valid", 1'b0, adc_valid_o);
      end
      tick();
      check_bit("reset_hold release", 1'b0, core_reset_o);
      loop_mode_i     = LOOP_NONE;
      adc_raw_valid_i = 1'b0;
      adc_raw_a_i     = '0;
      if (r == 0) begin
        pll_locked_i = 1'b0;  // Drop lock so the second round repeats the hold
        tick();
        tick();
        check_bit("reset_hold unlocked", 1'b0, core_reset_o);
      end
    end
  endtask

  task automatic test_adc_trim();
    raw_t ra, rb;
    logic v;
    loop_mode_i = LOOP_NONE;
    for (int i = 0; i < 32; i++) begin
      ra = raw_t'($urandom);
      rb = raw_t'($urandom);
      v  = 1'($urandom);
      adc_raw_a_i     = ra;
      adc_raw_b_i     = rb;
      adc_raw_valid_i = v;
      tick();
      check_sample("adc_trim adc_a", sample_t'(ra >> (ADC_RAW_W - SAMPLE_W)), adc_a_o);
      check_sample("adc_trim adc_b", sample_t'(rb >> (ADC_RAW_W - SAMPLE_W)), adc_b_o);
      check_bit("adc_trim adc_valid", v, adc_valid_o);
    end
  endtask

  // Two-cycle sum path observed on the DAC codes or on the ADC loop
  task automatic run_sum_stream(string name, bit to_adc, int count);
    int      dir_g[6] = '{8191, -8192, 8000, -8000, 8191, 0};
    int      dir_c[6] = '{1, -1, 500, -500, -8192, 0};
    sample_t exp_a[$];
    sample_t exp_b[$];
    sample_t ea, eb;
    loop_mode_i     = to_adc ? LOOP_ADC_FROM_DAC : LOOP_NONE;
    adc_raw_valid_i = 1'b0;  // Loop mode forces valid
    for (int i = 0; i <= count; i++) begin
      gen_a_i  = (i < 6) ? sample_t'(dir_g[i]) : sample_t'($urandom);
      ctrl_a_i = (i < 6) ? sample_t'(dir_c[i]) : sample_t'($urandom);
      gen_b_i  = (i < 6) ? sample_t'(dir_g[5-i]) : sample_t'($urandom);
      ctrl_b_i = (i < 6) ? sample_t'(dir_c[5-i]) : sample_t'($urandom);
      exp_a.push_back(clamp_sum(gen_a_i, ctrl_a_i));
      exp_b.push_back(clamp_sum(gen_b_i, ctrl_b_i));
      tick();
      if (i >= 1) begin  // Item i-1 is at the outputs now
        ea = exp_a.pop_front();
        eb = exp_b.pop_front();
        if (to_adc) begin
          check_sample({name, " adc_a"}, ea, adc_a_o);
          check_sample({name, " adc_b"}, eb, adc_b_o);
          check_bit({name, " adc_valid"}, 1'b1, adc_valid_o);
        end else begin
          check_dac({name, " dac_a"}, expected_code(ea), dac_a_o);
          check_dac({name, " dac_b"}, expected_code(eb), dac_b_o);
        end
      end
    end
  endtask

  task automatic test_mixer_dac();
    run_sum_stream("mixer_dac", 1'b0, 32);
  endtask

  task automatic test_adc_loop();
    run_sum_stream("adc_loop", 1'b1, 32);
  endtask

  task automatic test_dac_loop();
    dac_code_t exp_a[$];
    dac_code_t exp_b[$];
    loop_mode_i = LOOP_DAC_FROM_ADC;
    for (int i = 0; i <= 24; i++) begin
      adc_raw_a_i = raw_t'($urandom);
      adc_raw_b_i = raw_t'($urandom);
      exp_a.push_back(dac_code_t'(adc_raw_a_i >> (ADC_RAW_W - SAMPLE_W)));
      exp_b.push_back(dac_code_t'(adc_raw_b_i >> (ADC_RAW_W - SAMPLE_W)));
      tick();
      if (i >= 1) begin
        check_dac("dac_loop dac_a", exp_a.pop_front(), dac_a_o);
        check_dac("dac_loop dac_b", exp_b.pop_front(), dac_b_o);
      end
    end
  endtask

  task automatic test_trig_route();
    logic [DAISY_MODE_W-1:0] mode;
    logic                    ext, rdy, sync, sel;
    daisy_word_t             rx;
    for (int i = 0; i < 40; i++) begin
      mode = DAISY_MODE_W'($urandom);
      ext  = (i < 2) ? 1'b1 : 1'($urandom);
      rx   = ($urandom % 3 == 0) ? '0 : daisy_word_t'($urandom);
      if (i == 0) mode = 3'b001;  // Sync with nonzero word masks the pin
      if (i == 1) mode = 3'b010;  // Idle word outside sync
      if (i == 0) rx = 16'h0100;
      rdy = 1'($urandom);
      daisy_mode_i   = mode;
      ext_trig_pin_i = ext;
      daisy_rx_dat_i = rx;
      daisy_rx_rdy_i = rdy;
      scope_trig_i   = 1'($urandom);
      gen_trig_i     = 1'($urandom);
      sync = mode[DAISY_SYNC_BIT];
      sel  = mode[TRIG_SRC_GEN_BIT] ? gen_trig_i : scope_trig_i;
      tick();
      check_bit("trig_route trig_ext", ext & ~(sync & (rx != '0)), trig_ext_o);
      check_bit("trig_route trig_pin", sel, trig_pin_o);
      check_bit("trig_route trig_pin_oe", mode[TRIG_PIN_EN_BIT], trig_pin_oe_o);
      check_word("trig_route tx_dat", sync ? {DAISY_W{sel}} : DAISY_IDLE_WORD, daisy_tx_dat_o);
      check_bit("trig_route tx_dv", sync ? 1'b0 : rdy, daisy_tx_dv_o);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2eb4));
    reset_i         = 1'b1;
    pll_locked_i    = 1'b0;
    adc_raw_a_i     = '0;
    adc_raw_b_i     = '0;
    adc_raw_valid_i = 1'b0;
    loop_mode_i     = LOOP_NONE;
    gen_a_i         = '0;
    gen_b_i         = '0;
    ctrl_a_i        = '0;
    ctrl_b_i        = '0;
    ext_trig_pin_i  = 1'b0;
    daisy_mode_i    = '0;
    daisy_rx_dat_i  = '0;
    daisy_rx_rdy_i  = 1'b0;
    scope_trig_i    = 1'b0;
    gen_trig_i      = 1'b0;
    repeat (3) @(posedge adc_clk);  // Three reset cycles
    #1;
    reset_i = 1'b0;
    tick();
    test_reset_hold();
    test_adc_trim();
    test_mixer_dac();
    test_adc_loop();
    test_dac_loop();
    test_trig_route();
    if (error_count == 0) begin
      $display("test passed");
      $finish;
    end else
      stop_with_failure();
  end

endmodule

/* files.f */
rp_pkg.sv
rp_reset_seq.sv
rp_adc_capture.sv
rp_dac_mixer.sv
rp_dac_output.sv
rp_trig_route.sv
rp_frontend_top.sv
tb_rp_frontend.sv

/* Makefile */
TOP   := tb_rp_frontend
BUILD := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 --top-module $(TOP) --Mdir $(BUILD) -f files.f

run: build
	./$(BUILD)/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf $(BUILD) sim.log
